/* common/memPkg.sv */
package memPkg;

`include "memctrl_defs.svh"

    typedef logic [`MEM_ADDR_W-1:0] addrT;
    typedef logic [31:0]            wordT;
    typedef logic [7:0]             byteT;

    // bytes per access, 1, 2 or 4
    typedef logic [2:0]             lenT;

    // same codes as the old wait bus
    typedef enum logic [1:0] {
        ownNone  = 2'b00,
        ownData  = 2'b01,
        ownFetch = 2'b10
    } ownerT;

    typedef enum logic [1:0] {
        seqIdle,
        seqRead,
        seqWrite,
        seqDone
    } seqStateT;

endpackage

/* common/memReqIf.sv */
`timescale 1ns/1ps

interface memReqIf
    import memPkg::*;
();
    logic valid;
    logic isWrite;
    lenT  len;
    addrT addr;
    wordT wdata;
    logic done;
    wordT rdata;

    modport arb (
        output valid,
        output isWrite,
        output len,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    modport seq (
        input  valid,
        input  isWrite,
        input  len,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

/* common/memctrl_defs.svh */
`ifndef MEMCTRL_DEFS_SVH
`define MEMCTRL_DEFS_SVH

// byte address width of the shared RAM
`define MEM_ADDR_W 17

// number of bytes behind that address
`define MEM_DEPTH (1 << `MEM_ADDR_W)

// RAM read latency is one clock.
// a byte addressed in cycle k shows up on ramRdata in cycle k+1,
// and stays there as long as the address does not move

`endif

/* dv/memCtrlTb.sv */
`timescale 1ns/1ps
`include "memctrl_defs.svh"

module memCtrlTb
    import memPkg::*;
();
    localparam int waitLimit = 200;

    logic  clk;
    logic  rst;
    logic  ready;
    logic  ioBufferFull;
    logic  fetchEn;
    addrT  fetchAddr;
    logic  fetchDone;
    wordT  fetchInst;
    logic  dataEn;
    logic  dataWrite;
    lenT   dataLen;
    addrT  dataAddr;
    wordT  dataWdata;
    logic  dataDone;
    wordT  dataRdata;
    ownerT owner;
    addrT  ramAddr;
    logic  ramWe;
    byteT  ramWdata;
    byteT  ramRdata;

    byteT   shadow [0:`MEM_DEPTH-1];
    integer seed;
    logic   stallMode;
    time    dataDoneAt;
    time    fetchDoneAt;
    addrT   base;
    addrT   addrA;
    addrT   addrB;
    integer op;

    memCtrlTop uut (
        .clk          (clk),
        .rst          (rst),
        .ready        (ready),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataWrite    (dataWrite),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .owner        (owner),
        .ramAddr      (ramAddr),
        .ramWe        (ramWe),
        .ramWdata     (ramWdata),
        .ramRdata     (ramRdata)
    );

    ramModel ram (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input wordT expected, input wordT actual);
        failRun($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, expected,
                          actual));
    endtask

    // preload pattern, every address bit takes part
    function automatic byteT fillByte(input addrT a);
        return a[7:0] ^ a[15:8] ^ {a[16], 7'h2d};
    endfunction

    // little-endian, bytes above len stay zero
    function automatic wordT shadowWord(input addrT a, input lenT len);
        wordT w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[8*i +: 8] = shadow[addrT'(a + i)];
        end
        return w;
    endfunction

    task automatic storeShadow(input addrT a, input lenT len, input wordT w);
        for (int i = 0; i < int'(len); i++) begin
            shadow[addrT'(a + i)] = w[8*i +: 8];
        end
    endtask

    function automatic lenT lenFor(input integer r);
        case (r & 3)
            0: return 3'd1;
            1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    task automatic checkResetState();
        resetFetchDone: assert (fetchDone === 1'b0)
            else reportMismatch("fetchDone", 1'b0, fetchDone);
        resetDataDone: assert (dataDone === 1'b0)
            else reportMismatch("dataDone", 1'b0, dataDone);
        resetRamWe: assert (ramWe === 1'b0)
            else reportMismatch("ramWe", 1'b0, ramWe);
        resetOwner: assert (owner === ownNone)
            else reportMismatch("owner", ownNone, owner);
    endtask

    // entered on a falling edge, returns on the falling edge of the done cycle
    task automatic doFetch(input addrT a, input logic checkLatency);
        int   cycles;
        wordT expected;
        fetchEn   = 1'b1;
        fetchAddr = a;
        cycles    = 1;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > waitLimit) begin
                failRun("fetch request timed out waiting for fetchDone");
            end
        end while (fetchDone !== 1'b1);
        fetchDoneAt = $time;
        expected    = shadowWord(a, 3'd4);
        fetchInstOk: assert (fetchInst === expected)
            else reportMismatch("fetchInst", expected, fetchInst);
        if (checkLatency) begin
            // grant, issue, four captures, done
            fetchLatencyOk: assert (cycles == 7)
                else failRun($sformatf("fetch took %0d cycles to fetchDone instead of 7",
                                       cycles));
        end
        fetchEn = 1'b0;
    endtask

    task automatic doData(input logic write, input lenT len, input addrT a, input wordT w);
        int   cycles;
        wordT expected;
        dataEn    = 1'b1;
        dataWrite = write;
        dataLen   = len;
        dataAddr  = a;
        dataWdata = w;
        cycles    = 1;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > waitLimit) begin
                failRun("data request timed out waiting for dataDone");
            end
        end while (dataDone !== 1'b1);
        dataDoneAt = $time;
        if (write) begin
            storeShadow(a, len, w);
        end else begin
            expected = shadowWord(a, len);
            dataRdataOk: assert (dataRdata === expected)
                else reportMismatch("dataRdata", expected, dataRdata);
        end
        dataEn = 1'b0;
    endtask

    // both clients raise their enables on the same edge
    task automatic contend(input addrT fa, input logic write, input lenT len, input addrT da,
                           input wordT w);
        fork
            doFetch(fa, 1'b0);
            doData(write, len, da, w);
            begin
                int waited;
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                    if (waited > waitLimit) begin
                        failRun("neither client was granted the RAM before the timeout");
                    end
                end while (owner === ownNone);
                firstOwnerOk: assert (owner === ownData)
                    else reportMismatch("owner", ownData, owner);
            end
        join
        doneOrderOk: assert (dataDoneAt < fetchDoneAt)
            else failRun("fetchDone arrived before dataDone while both clients competed");
    endtask

    always @(negedge clk) begin
        if (stallMode) begin
            ready        <= ($random(seed) & 3) != 0;
            ioBufferFull <= ($random(seed) & 7) == 0;
        end
    end

    noWriteInStall: assert property (
        @(posedge clk) disable iff (rst)
        !(ready && !ioBufferFull) |-> !ramWe
    ) else failRun("ramWe was high in a stall cycle");

    fetchDoneToOwner: assert property (
        @(posedge clk) disable iff (rst)
        fetchDone |-> owner == ownFetch
    ) else failRun("fetchDone pulsed while the fetch client did not own the RAM");

    dataDoneToOwner: assert property (
        @(posedge clk) disable iff (rst)
        dataDone |-> owner == ownData
    ) else failRun("dataDone pulsed while the data client did not own the RAM");

    fetchSinglePulse: assert property (
        @(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone
    ) else failRun("fetchDone lasted longer than one cycle");

    dataSinglePulse: assert property (
        @(posedge clk) disable iff (rst)
        dataDone |=> !dataDone
    ) else failRun("dataDone lasted longer than one cycle");

    ownerIdleAfterDone: assert property (
        @(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |=> owner == ownNone
    ) else failRun("owner did not return to ownNone after a done pulse");

    initial begin
        seed         = 32'h7c04;
        rst          = 1'b1;
        ready        = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataWrite    = 1'b0;
        dataLen      = 3'd4;
        dataAddr     = '0;
        dataWdata    = '0;
        stallMode    = 1'b0;
        dataDoneAt   = 0;
        fetchDoneAt  = 0;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            shadow[i]  = fillByte(addrT'(i));
            ram.mem[i] = shadow[i];
        end

        repeat (2) begin
            @(negedge clk);
            checkResetState();
        end
        rst = 1'b0;
        @(negedge clk);
        checkResetState();

        // plain fetches, fixed latency
        repeat (4) begin
            doFetch(addrT'($random(seed)), 1'b1);
            @(negedge clk);
        end
        // wraps past the top of the address space
        doFetch(addrT'(`MEM_DEPTH - 2), 1'b1);
        @(negedge clk);

        // store, then a full word and a same-length load at that address
        for (int k = 0; k < 3; k++) begin
            repeat (3) begin
                addrA = addrT'($random(seed));
                doData(1'b1, lenFor(k), addrA, $random(seed));
                @(negedge clk);
                doData(1'b0, 3'd4, addrA, '0);
                @(negedge clk);
                doData(1'b0, lenFor(k), addrA, '0);
                @(negedge clk);
            end
        end

        // data beats fetch
        addrA = addrT'($random(seed));
        addrB = addrT'($random(seed));
        contend(addrB, 1'b0, 3'd2, addrA, '0);
        @(negedge clk);
        contend(addrA, 1'b1, 3'd4, addrA, $random(seed));
        @(negedge clk);
        contend(addrB, 1'b1, 3'd1, addrA, $random(seed));
        @(negedge clk);

        // mixed traffic in a small window so loads hit earlier stores
        stallMode = 1'b1;
        base      = addrT'($random(seed));
        repeat (40) begin
            op    = $random(seed) & 3;
            addrA = addrT'(base + ($random(seed) & 32'h1f));
            addrB = addrT'(base + ($random(seed) & 32'h1f));
            case (op)
                0: doFetch(addrA, 1'b0);
                1: doData(1'b1, lenFor($random(seed)), addrA, $random(seed));
                2: doData(1'b0, lenFor($random(seed)), addrA, '0);
                default: contend(addrB, ($random(seed) & 1) != 0, lenFor($random(seed)),
                                 addrA, $random(seed));
            endcase
            @(negedge clk);
        end
        stallMode = 1'b0;
        @(negedge clk);
        ready        = 1'b1;
        ioBufferFull = 1'b0;
        repeat (2) @(negedge clk);

        $display("Verification passed");
        $finish;
    end

endmodule

/* dv/ramModel.sv */
`timescale 1ns/1ps
`include "memctrl_defs.svh"

module ramModel
    import memPkg::*;
(
    input  logic clk,
    input  addrT addr,
    input  logic we,
    input  byteT wdata,
    output byteT rdata
);
    // contents are preloaded by the testbench
    byteT mem [0:`MEM_DEPTH-1];

    // registered read, so the byte shows up one clock after its address
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* memctrl/byteSequencer.sv */
`timescale 1ns/1ps

module byteSequencer
    import memPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic ready,
    input  logic ioBufferFull,

    memReqIf.seq req,

    output addrT ramAddr,
    output logic ramWe,
    output byteT ramWdata,
    input  byteT ramRdata
);
    seqStateT state;
    lenT      idx;
    lenT      nextIdx;
    lenT      capIdx;
    addrT     issueAddr;
    addrT     heldAddr;
    wordT     acc;
    logic     adv;
    logic     start;

    assign adv     = ready && !ioBufferFull;
    assign start   = (state == seqIdle) && adv && req.valid;
    assign nextIdx = idx + 3'd1;

    // byte returned now was issued one advancing cycle ago
    assign capIdx  = idx - 3'd1;

    assign issueAddr = req.addr + addrT'(idx);

    // in a stall the last issued address stays on the bus,
    // so ramRdata still holds the byte waiting to be captured
    assign ramAddr = adv ? issueAddr : heldAddr;

    always_ff @(posedge clk) begin
        heldAddr <= ramAddr;
    end

    assign ramWdata = req.wdata[{idx[1:0], 3'b000} +: 8];
    assign ramWe    = adv && req.valid && req.isWrite &&
                      ((state == seqIdle) || (state == seqWrite));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            idx   <= '0;
        end else begin
            case (state)
                seqIdle: begin
                    if (start) begin
                        idx <= 3'd1;
                        if (!req.isWrite) begin
                            state <= seqRead;
                        end else if (req.len == 3'd1) begin
                            state <= seqDone;
                        end else begin
                            state <= seqWrite;
                        end
                    end
                end
                seqRead: begin
                    if (adv) begin
                        if (idx == req.len) begin
                            state <= seqDone;
                        end else begin
                            idx <= nextIdx;
                        end
                    end
                end
                seqWrite: begin
                    if (adv) begin
                        if (nextIdx == req.len) begin
                            state <= seqDone;
                        end else begin
                            idx <= nextIdx;
                        end
                    end
                end
                seqDone: begin
                    // done pulse is a single cycle, stall or not
                    state <= seqIdle;
                    idx   <= '0;
                end
                default: begin
                    state <= seqIdle;
                    idx   <= '0;
                end
            endcase
        end
    end

    // little-endian assembly, upper bytes stay zero
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if ((state == seqRead) && adv) begin
            acc[{capIdx[1:0], 3'b000} +: 8] <= ramRdata;
        end
    end

    assign req.done  = (state == seqDone);
    assign req.rdata = acc;

    // a stall freezes the byte counter, so no byte is issued twice
    stallHolds: assert property (
        @(posedge clk) disable iff (rst)
        !adv && (state != seqDone) |=> $stable(state) && $stable(idx) && $stable(acc)
    );

    legalLen: assert property (
        @(posedge clk) disable iff (rst)
        req.valid |-> req.len inside {3'd1, 3'd2, 3'd4}
    );

endmodule

/* memctrl/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter
    import memPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  ready,
    input  logic  ioBufferFull,

    input  logic  fetchEn,
    input  addrT  fetchAddr,
    output logic  fetchDone,
    output wordT  fetchInst,

    input  logic  dataEn,
    input  logic  dataWrite,
    input  lenT   dataLen,
    input  addrT  dataAddr,
    input  wordT  dataWdata,
    output logic  dataDone,
    output wordT  dataRdata,

    output ownerT owner,
    memReqIf.arb  req
);
    logic adv;
    logic grant;

    assign adv = ready && !ioBufferFull;

    // only grant from idle, data first
    assign grant = adv && !req.valid && (dataEn || fetchEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            owner     <= ownNone;
            req.valid <= 1'b0;
        end else if (req.done) begin
            // one idle cycle between requests
            owner     <= ownNone;
            req.valid <= 1'b0;
        end else if (grant) begin
            req.valid <= 1'b1;
            if (dataEn) begin
                owner <= ownData;
            end else begin
                owner <= ownFetch;
            end
        end
    end

    // operands held until done
    always_ff @(posedge clk) begin
        if (grant) begin
            if (dataEn) begin
                req.isWrite <= dataWrite;
                req.len     <= dataLen;
                req.addr    <= dataAddr;
                req.wdata   <= dataWdata;
            end else begin
                // fetch is always a full word read
                req.isWrite <= 1'b0;
                req.len     <= 3'd4;
                req.addr    <= fetchAddr;
                req.wdata   <= '0;
            end
        end
    end

    // done only reaches the owner
    assign fetchDone = req.done && (owner == ownFetch);
    assign dataDone  = req.done && (owner == ownData);
    assign fetchInst = (owner == ownFetch) ? req.rdata : '0;
    assign dataRdata = (owner == ownData) ? req.rdata : '0;

    // owning client keeps its enable up until its done pulse
    ownerHoldsEnable: assert property (
        @(posedge clk) disable iff (rst)
        req.valid && !req.done |-> ((owner == ownData) ? dataEn : fetchEn)
    );

    // the sequencer must never finish a request nobody owns
    doneHasOwner: assert property (
        @(posedge clk) disable iff (rst)
        req.done |-> owner != ownNone
    );

endmodule

/* sim.f */
+incdir+common
common/memPkg.sv
common/memReqIf.sv
memctrl/memArbiter.sv
memctrl/byteSequencer.sv
source/memCtrlTop.sv
dv/ramModel.sv
dv/memCtrlTb.sv

/* source/memCtrlTop.sv */
`timescale 1ns/1ps

module memCtrlTop
    import memPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  ready,
    input  logic  ioBufferFull,

    input  logic  fetchEn,
    input  addrT  fetchAddr,
    output logic  fetchDone,
    output wordT  fetchInst,

    input  logic  dataEn,
    input  logic  dataWrite,
    input  lenT   dataLen,
    input  addrT  dataAddr,
    input  wordT  dataWdata,
    output logic  dataDone,
    output wordT  dataRdata,

    output ownerT owner,

    output addrT  ramAddr,
    output logic  ramWe,
    output byteT  ramWdata,
    input  byteT  ramRdata
);
    memReqIf req ();

    memArbiter arbiter (
        .clk          (clk),
        .rst          (rst),
        .ready        (ready),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataWrite    (dataWrite),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .owner        (owner),
        .req          (req.arb)
    );

    // one granted request at a time
    byteSequencer sequencer (
        .clk          (clk),
        .rst          (rst),
        .ready        (ready),
        .ioBufferFull (ioBufferFull),
        .req          (req.seq),
        .ramAddr      (ramAddr),
        .ramWe        (ramWe),
        .ramWdata     (ramWdata),
        .ramRdata     (ramRdata)
    );

endmodule
